//--- app_data_arb.sv
module app_data_arb (
    input  logic clk,
    input  logic rst_n,
    input  logic i_ip_req,
    input  logic i_ip_rel,
    input  logic i_cpu_req,
    input  logic i_cpu_rel,
    output logic o_ip_grant,
    output logic o_cpu_grant
);

    import buffer_share_pkg::*;

    app_grant_e state_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= GRANT_NONE;
        end else begin
            case (state_q)
                GRANT_NONE: begin
                    // IP wins a tie
                    if (i_ip_req) begin
                        state_q <= GRANT_IP;
                    end else if (i_cpu_req) begin
                        state_q <= GRANT_CPU;
                    end
                end
                GRANT_IP: begin
                    if (i_ip_rel) begin
                        state_q <= GRANT_NONE;
                    end
                end
                GRANT_CPU: begin
                    if (i_cpu_rel) begin
                        state_q <= GRANT_NONE;
                    end
                end
                default: state_q <= GRANT_NONE;
            endcase
        end
    end

    assign o_ip_grant  = (state_q == GRANT_IP);
    assign o_cpu_grant = (state_q == GRANT_CPU);

endmodule

//--- buf_own_if.sv
interface buf_own_if;

    logic ip_grant;
    logic cpu_grant;
    logic cpu_rel;
    logic ip_rel;

    // Arbiter side
    modport arb (
        output ip_grant,
        output cpu_grant,
        input  cpu_rel,
        input  ip_rel
    );

    // Local agent side
    modport cpu (
        input  cpu_grant,
        output cpu_rel
    );

endinterface

//--- buf_owner_arb.sv
module buf_owner_arb #(
    parameter buffer_share_pkg::buf_owner_e RESET_OWNER = buffer_share_pkg::OWNER_IP
) (
    input  logic      clk,
    input  logic      rst_n,
    buf_own_if.arb    own
);

    import buffer_share_pkg::*;

    buf_owner_e owner_q;

    // Only the current owner may hand the buffer over
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner_q <= RESET_OWNER;
        end else begin
            case (owner_q)
                OWNER_IP: begin
                    if (own.ip_rel) begin
                        owner_q <= OWNER_CPU;
                    end
                end
                OWNER_CPU: begin
                    if (own.cpu_rel) begin
                        owner_q <= OWNER_IP;
                    end
                end
                default: owner_q <= RESET_OWNER;
            endcase
        end
    end

    assign own.ip_grant  = (owner_q == OWNER_IP);
    assign own.cpu_grant = (owner_q == OWNER_CPU);

endmodule

//--- buffer_share_pkg.sv
package buffer_share_pkg;

    // ********************************************************
    // Ownership encodings
    // ********************************************************

    // Current owner of a shared buffer
    typedef enum logic {
        OWNER_IP  = 1'b0,
        OWNER_CPU = 1'b1
    } buf_owner_e;

    // App-data arbiter state
    typedef enum logic [1:0] {
        GRANT_NONE = 2'b00,
        GRANT_IP   = 2'b01,
        GRANT_CPU  = 2'b10
    } app_grant_e;

    // ********************************************************
    // Buffer geometry
    // ********************************************************

    localparam int RXBUF_AW = 6;
    localparam int TXBUF_AW = 6;
    localparam int BUF_DW   = 32;

    // Size word carries the received length in its upper half
    localparam logic [RXBUF_AW-1:0] RX_SIZE_WORD_ADDR = RXBUF_AW'(1);
    localparam int                  RX_SIZE_W         = 16;

    // LED bands
    localparam logic [RX_SIZE_W-1:0] LED_R_MAX = RX_SIZE_W'(10);
    localparam logic [RX_SIZE_W-1:0] LED_G_MAX = RX_SIZE_W'(20);

    // ********************************************************
    // TX message source
    // ********************************************************

    localparam int TX_HOLD_CYCLES = 24;
    localparam int TX_HOLD_W      = 5;
    localparam int TX_MSG_LEN     = 5;

    localparam logic [BUF_DW-1:0] TX_MSG_WORDS [TX_MSG_LEN] = '{
        32'h0a01a8c0,
        32'h045704d2,
        32'h00000007,
        32'h626f6f66,
        32'h000a7261
    };

endpackage

//--- buffer_share_top.sv
module buffer_share_top (
    input  logic                                 clk,
    input  logic                                 rst_n,

    input  logic                                 i_app_ip_req,
    input  logic                                 i_app_ip_rel,
    input  logic                                 i_app_cpu_req,
    input  logic                                 i_app_cpu_rel,
    output logic                                 o_app_ip_grant,
    output logic                                 o_app_cpu_grant,

    input  logic                                 i_rxbuf_ip_rel,
    input  logic [buffer_share_pkg::RXBUF_AW-1:0] i_rxbuf_addr,
    input  logic                                 i_rxbuf_ce,
    input  logic                                 i_rxbuf_we,
    input  logic [buffer_share_pkg::BUF_DW-1:0]   i_rxbuf_wdata,
    output logic                                 o_rxbuf_ip_grant,

    input  logic                                 i_txbuf_ip_rel,
    input  logic [buffer_share_pkg::TXBUF_AW-1:0] i_txbuf_addr,
    output logic [buffer_share_pkg::BUF_DW-1:0]   o_txbuf_rdata,
    output logic                                 o_txbuf_ip_grant,

    output logic                                 o_led_r,
    output logic                                 o_led_g,
    output logic                                 o_led_b
);

    import buffer_share_pkg::*;

    // ********************************************************
    // App-data arbiter
    // ********************************************************

    app_data_arb u_app_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_ip_req    (i_app_ip_req),
        .i_ip_rel    (i_app_ip_rel),
        .i_cpu_req   (i_app_cpu_req),
        .i_cpu_rel   (i_app_cpu_rel),
        .o_ip_grant  (o_app_ip_grant),
        .o_cpu_grant (o_app_cpu_grant)
    );

    // ********************************************************
    // RX buffer owned by the IP side out of reset
    // ********************************************************

    buf_own_if rx_own ();

    assign rx_own.ip_rel    = i_rxbuf_ip_rel;
    assign o_rxbuf_ip_grant = rx_own.ip_grant;

    buf_owner_arb #(
        .RESET_OWNER (OWNER_IP)
    ) u_rx_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .own   (rx_own.arb)
    );

    rx_size_monitor u_rx_mon (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_rxbuf_addr  (i_rxbuf_addr),
        .i_rxbuf_ce    (i_rxbuf_ce),
        .i_rxbuf_we    (i_rxbuf_we),
        .i_rxbuf_wdata (i_rxbuf_wdata),
        .own           (rx_own.cpu),
        .o_led_r       (o_led_r),
        .o_led_g       (o_led_g),
        .o_led_b       (o_led_b)
    );

    // ********************************************************
    // TX buffer owned by the CPU side out of reset
    // ********************************************************

    buf_own_if tx_own ();

    assign tx_own.ip_rel    = i_txbuf_ip_rel;
    assign o_txbuf_ip_grant = tx_own.ip_grant;

    buf_owner_arb #(
        .RESET_OWNER (OWNER_CPU)
    ) u_tx_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .own   (tx_own.arb)
    );

    tx_msg_source u_tx_src (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_txbuf_addr  (i_txbuf_addr),
        .own           (tx_own.cpu),
        .o_txbuf_rdata (o_txbuf_rdata)
    );

endmodule

//--- compile.f
buffer_share_pkg.sv
buf_own_if.sv
buf_owner_arb.sv
app_data_arb.sv
rx_size_monitor.sv
tx_msg_source.sv
buffer_share_top.sv
tb_buffer_share.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_buffer_share -f compile.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^=== PASS ===$"; then
    exit 0
fi
exit 1

//--- rx_size_monitor.sv
module rx_size_monitor (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [buffer_share_pkg::RXBUF_AW-1:0] i_rxbuf_addr,
    input  logic                                 i_rxbuf_ce,
    input  logic                                 i_rxbuf_we,
    input  logic [buffer_share_pkg::BUF_DW-1:0]   i_rxbuf_wdata,
    buf_own_if.cpu                               own,
    output logic                                 o_led_r,
    output logic                                 o_led_g,
    output logic                                 o_led_b
);

    import buffer_share_pkg::*;

    logic [RX_SIZE_W-1:0] rx_size_q;
    logic                 cpu_rel_q;
    logic                 size_wr;

    assign size_wr = i_rxbuf_ce && i_rxbuf_we && (i_rxbuf_addr == RX_SIZE_WORD_ADDR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_size_q <= '0;
            cpu_rel_q <= 1'b0;
        end else begin
            // Hand the buffer straight back
            cpu_rel_q <= own.cpu_grant;
            if (size_wr) begin
                rx_size_q <= i_rxbuf_wdata[BUF_DW-1 -: RX_SIZE_W];
            end
        end
    end

    assign own.cpu_rel = cpu_rel_q;

    // Zero lights nothing
    assign o_led_r = (rx_size_q != '0) && (rx_size_q <= LED_R_MAX);
    assign o_led_g = (rx_size_q > LED_R_MAX) && (rx_size_q <= LED_G_MAX);
    assign o_led_b = (rx_size_q > LED_G_MAX);

endmodule

//--- tb_buffer_share.sv
module tb_buffer_share;

    timeunit 1ns;
    timeprecision 1ps;

    import buffer_share_pkg::*;

    localparam int CLK_HALF       = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_CYCLES     = 3000;
    // Reset plus stimulus, with margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic clk;
    logic rst_n;
    logic i_app_ip_req, i_app_ip_rel, i_app_cpu_req, i_app_cpu_rel;
    logic o_app_ip_grant, o_app_cpu_grant;
    logic i_rxbuf_ip_rel, i_rxbuf_ce, i_rxbuf_we, o_rxbuf_ip_grant;
    logic [RXBUF_AW-1:0] i_rxbuf_addr;
    logic [BUF_DW-1:0]   i_rxbuf_wdata;
    logic i_txbuf_ip_rel, o_txbuf_ip_grant;
    logic [TXBUF_AW-1:0] i_txbuf_addr;
    logic [BUF_DW-1:0]   o_txbuf_rdata;
    logic o_led_r, o_led_g, o_led_b;

    // Reference model state
    app_grant_e           m_app;
    buf_owner_e           m_rx_owner, m_tx_owner;
    logic                 m_rx_rel, m_tx_rel;
    int                   m_tx_cnt;
    logic [RX_SIZE_W-1:0] m_size;
    logic [BUF_DW-1:0]    m_rdata;
    logic [2:0]           exp_led;

    logic [31:0] lfsr_state = 32'hafd6f923;
    int value_errs  = 0;
    int other_errs  = 0;
    int cycle_cnt   = 0;
    int rx_low_run  = 0;
    int tx_low_run  = 0;

    buffer_share_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ********************************************************
    // Random source
    // ********************************************************

    function automatic logic rand_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_field(int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], rand_bit()};
        end
        return val;
    endfunction

    // LED class as {r, g, b} from the size bands
    function automatic logic [2:0] led_band(logic [RX_SIZE_W-1:0] size);
        if (size == '0) return 3'b000;
        else if (size <= LED_R_MAX) return 3'b100;
        else if (size <= LED_G_MAX) return 3'b010;
        else return 3'b001;
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            value_errs++;
            $display("** Error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic check_reset_state();
        check_value("reset_txbuf_ip_grant", 32'd0, 32'(o_txbuf_ip_grant));
        check_value("reset_rxbuf_ip_grant", 32'd1, 32'(o_rxbuf_ip_grant));
        check_value("reset_app_ip_grant", 32'd0, 32'(o_app_ip_grant));
        check_value("reset_app_cpu_grant", 32'd0, 32'(o_app_cpu_grant));
        check_value("reset_leds", 32'd0, 32'({o_led_r, o_led_g, o_led_b}));
        check_value("reset_txbuf_rdata", 32'd0, o_txbuf_rdata);
    endtask

    task automatic drive_random_inputs();
        logic [RX_SIZE_W-1:0] size;
        i_app_ip_req   <= rand_bit();
        i_app_cpu_req  <= rand_bit();
        i_app_ip_rel   <= (rand_field(2) == 32'd0);
        i_app_cpu_rel  <= (rand_field(2) == 32'd0);
        i_rxbuf_ip_rel <= (rand_field(3) == 32'd0);
        i_txbuf_ip_rel <= (rand_field(2) == 32'd0);
        i_rxbuf_addr   <= (rand_field(3) < 32'd3) ? RX_SIZE_WORD_ADDR : RXBUF_AW'(rand_field(6));
        i_rxbuf_ce     <= (rand_field(2) != 32'd0);
        i_rxbuf_we     <= (rand_field(2) != 32'd0);
        // Mostly small sizes
        if (rand_field(3) != 32'd0) begin
            size = RX_SIZE_W'(rand_field(5) % 32'd26);
        end else begin
            size = RX_SIZE_W'(rand_field(16));
        end
        i_rxbuf_wdata  <= {size, 16'(rand_field(16))};
        i_txbuf_addr   <= rand_bit() ? TXBUF_AW'(rand_field(3)) : TXBUF_AW'(rand_field(6));
    endtask

    // ********************************************************
    // Cycle model
    // ********************************************************

    always @(posedge clk) begin
        if (!rst_n) begin
            m_app      <= GRANT_NONE;
            m_rx_owner <= OWNER_IP;
            m_rx_rel   <= 1'b0;
            m_tx_owner <= OWNER_CPU;
            m_tx_rel   <= 1'b0;
            m_tx_cnt   <= 0;
            m_size     <= '0;
            m_rdata    <= '0;
        end else begin
            case (m_app)
                GRANT_NONE: m_app <= i_app_ip_req ? GRANT_IP
                                   : (i_app_cpu_req ? GRANT_CPU : GRANT_NONE);
                GRANT_IP:   m_app <= i_app_ip_rel ? GRANT_NONE : GRANT_IP;
                GRANT_CPU:  m_app <= i_app_cpu_rel ? GRANT_NONE : GRANT_CPU;
                default:    m_app <= GRANT_NONE;
            endcase
            if (m_rx_owner == OWNER_IP && i_rxbuf_ip_rel) m_rx_owner <= OWNER_CPU;
            else if (m_rx_owner == OWNER_CPU && m_rx_rel) m_rx_owner <= OWNER_IP;
            m_rx_rel <= (m_rx_owner == OWNER_CPU);
            if (m_tx_owner == OWNER_IP && i_txbuf_ip_rel) m_tx_owner <= OWNER_CPU;
            else if (m_tx_owner == OWNER_CPU && m_tx_rel) m_tx_owner <= OWNER_IP;
            m_tx_cnt <= (m_tx_owner == OWNER_CPU) ? m_tx_cnt + 1 : 0;
            m_tx_rel <= (m_tx_owner == OWNER_CPU) && (m_tx_cnt == TX_HOLD_CYCLES - 1);
            if (i_rxbuf_ce && i_rxbuf_we && i_rxbuf_addr == RX_SIZE_WORD_ADDR) begin
                m_size <= i_rxbuf_wdata[BUF_DW-1 -: RX_SIZE_W];
            end
            if (int'(i_txbuf_addr) < TX_MSG_LEN) m_rdata <= TX_MSG_WORDS[int'(i_txbuf_addr)];
            else m_rdata <= '0;
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            exp_led = led_band(m_size);
            check_value("app_ip_grant", 32'(m_app == GRANT_IP), 32'(o_app_ip_grant));
            check_value("app_cpu_grant", 32'(m_app == GRANT_CPU), 32'(o_app_cpu_grant));
            check_value("rxbuf_ip_grant", 32'(m_rx_owner == OWNER_IP), 32'(o_rxbuf_ip_grant));
            check_value("txbuf_ip_grant", 32'(m_tx_owner == OWNER_IP), 32'(o_txbuf_ip_grant));
            check_value("leds", 32'(exp_led), 32'({o_led_r, o_led_g, o_led_b}));
            check_value("txbuf_rdata", m_rdata, o_txbuf_rdata);
            assert (!(o_app_ip_grant && o_app_cpu_grant)) else begin
                other_errs++;
                $display("** Error: both app-data grants are high at once");
            end
            if (!o_rxbuf_ip_grant) begin
                rx_low_run++;
            end else begin
                assert (rx_low_run == 0 || rx_low_run == 2) else begin
                    other_errs++;
                    $display("** Error: RX grant stayed low for %0d cycles instead of 2",
                             rx_low_run);
                end
                rx_low_run = 0;
            end
            if (!o_txbuf_ip_grant) begin
                tx_low_run++;
            end else begin
                assert (tx_low_run == 0 || tx_low_run == TX_HOLD_CYCLES + 1) else begin
                    other_errs++;
                    $display("** Error: TX grant came back after %0d cycles instead of %0d",
                             tx_low_run, TX_HOLD_CYCLES + 1);
                end
                tx_low_run = 0;
            end
        end
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst_n         = 1'b0;
        i_app_ip_req  = 1'b0;
        i_app_ip_rel  = 1'b0;
        i_app_cpu_req = 1'b0;
        i_app_cpu_rel = 1'b0;
        i_rxbuf_ip_rel = 1'b0;
        i_rxbuf_addr  = '0;
        i_rxbuf_ce    = 1'b0;
        i_rxbuf_we    = 1'b0;
        i_rxbuf_wdata = '0;
        i_txbuf_ip_rel = 1'b0;
        i_txbuf_addr  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_reset_state();
        repeat (NUM_CYCLES) begin
            @(posedge clk);
            drive_random_inputs();
        end
        // Let the last falling-edge checks finish first
        repeat (3) @(posedge clk);
        $display("Errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- tx_msg_source.sv
module tx_msg_source (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [buffer_share_pkg::TXBUF_AW-1:0] i_txbuf_addr,
    buf_own_if.cpu                               own,
    output logic [buffer_share_pkg::BUF_DW-1:0]   o_txbuf_rdata
);

    import buffer_share_pkg::*;

    logic [BUF_DW-1:0]    msg_word;
    logic [BUF_DW-1:0]    rdata_q;
    logic [TX_HOLD_W-1:0] hold_cnt_q;
    logic                 cpu_rel_q;

    // ********************************************************
    // Message lookup
    // ********************************************************

    always_comb begin
        msg_word = '0;
        for (int i = 0; i < TX_MSG_LEN; i++) begin
            if (i_txbuf_addr == TXBUF_AW'(i)) begin
                msg_word = TX_MSG_WORDS[i];
            end
        end
    end

    // ********************************************************
    // Hold period while the CPU side owns the buffer
    // ********************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_q    <= '0;
            hold_cnt_q <= '0;
            cpu_rel_q  <= 1'b0;
        end else begin
            rdata_q <= msg_word;
            if (own.cpu_grant) begin
                hold_cnt_q <= hold_cnt_q + 1'b1;
            end else begin
                hold_cnt_q <= '0;
            end
            // One-cycle pulse at end of hold
            cpu_rel_q <= own.cpu_grant && (hold_cnt_q == TX_HOLD_W'(TX_HOLD_CYCLES - 1));
        end
    end

    assign own.cpu_rel   = cpu_rel_q;
    assign o_txbuf_rdata = rdata_q;

endmodule
